// File: testbench/id_stim.txt
# test op inst pc es_en es_a es_val ms_en ms_a ms_val ws_en ws_a ws_val es_pend ms_pend es_allowin
#   alu flags(sa pc imm 8 gr_we mem_we load) dest imm rs rt taken target; ops W R I C S H
1 I 00000821 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 04 01 0821 0 0 0 0
1 I 00001023 1000 0 0 0 0 0 0 0 0 0 0 0 1 002 04 02 1023 0 0 0 0
1 I 0000182a 1000 0 0 0 0 0 0 0 0 0 0 0 1 004 04 03 182a 0 0 0 0
1 I 0000202b 1000 0 0 0 0 0 0 0 0 0 0 0 1 008 04 04 202b 0 0 0 0
1 I 00002824 1000 0 0 0 0 0 0 0 0 0 0 0 1 010 04 05 2824 0 0 0 0
1 I 00003027 1000 0 0 0 0 0 0 0 0 0 0 0 1 020 04 06 3027 0 0 0 0
1 I 00003825 1000 0 0 0 0 0 0 0 0 0 0 0 1 040 04 07 3825 0 0 0 0
1 I 00004026 1000 0 0 0 0 0 0 0 0 0 0 0 1 080 04 08 4026 0 0 0 0
1 I 000048c0 1000 0 0 0 0 0 0 0 0 0 0 0 1 100 44 09 48c0 0 0 0 0
1 I 00005042 1000 0 0 0 0 0 0 0 0 0 0 0 1 200 44 0a 5042 0 0 0 0
1 I 00005883 1000 0 0 0 0 0 0 0 0 0 0 0 1 400 44 0b 5883 0 0 0 0
1 I 240c1234 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 14 0c 1234 0 0 0 0
1 I 3c0dabcd 1000 0 0 0 0 0 0 0 0 0 0 0 1 800 14 0d abcd 0 0 0 0
1 I 8c0e0008 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 15 0e 0008 0 0 0 0
1 I ac0f0004 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 12 00 0004 0 0 0 0
1 I fc000000 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0000 0 0 0 0
2 R 0 0 0 0 0 0 0 0 1 3 0 0 0 1 0 0 0 0 0 0 0 0
2 R 0 0 0 0 0 0 0 0 1 5 0 0 0 1 0 0 0 0 0 0 0 0
2 W 0 0 0 0 0 0 0 0 1 0 deadbeef 0 0 1 0 0 0 0 0 0 0 0
2 C 00650821 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 04 01 0821 0 0 0 0
2 C 00030821 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 04 01 0821 0 0 0 0
3 W 0 0 0 0 0 0 0 0 1 6 66666666 0 0 1 0 0 0 0 0 0 0 0
3 I 00c60821 1000 1 6 eeee0001 1 6 aaaa0002 1 6 33330003 0 0 1 001 04 01 0821 eeee0001 eeee0001 0 0
3 I 00c60821 1000 0 0 0 1 6 aaaa0002 1 6 33330003 0 0 1 001 04 01 0821 aaaa0002 aaaa0002 0 0
3 I 00c60821 1000 0 0 0 0 0 0 1 6 44440004 0 0 1 001 04 01 0821 44440004 44440004 0 0
3 I 00c60821 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 04 01 0821 44440004 44440004 0 0
4 S 00c60821 1000 1 6 55550005 0 0 0 0 0 0 1 0 1 001 04 01 0821 55550005 55550005 0 0
4 S 00c60821 1000 0 0 0 1 6 77770007 0 0 0 0 1 1 001 04 01 0821 77770007 77770007 0 0
5 W 0 0 0 0 0 0 0 0 1 7 80000010 0 0 1 0 0 0 0 0 0 0 0
5 W 0 0 0 0 0 0 0 0 1 1 00000001 0 0 1 0 0 0 0 0 0 0 0
5 I 10c60004 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0004 44440004 44440004 1 1014
5 I 14c0fffe 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 1f fffe 44440004 0 1 0ffc
5 I 04e10008 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0008 80000010 1 0 0
5 I 04e00008 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0008 80000010 0 1 1024
5 I 1cc00010 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0010 44440004 0 1 1044
5 I 18e00003 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0003 80000010 0 1 1010
5 I 18c00003 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0003 44440004 0 0 0
5 I 08000400 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0400 0 0 1 1000
5 I 0c000800 1000 0 0 0 0 0 0 0 0 0 0 0 1 001 2c 1f 0800 0 0 1 2000
5 I 00c00008 1000 0 0 0 0 0 0 0 0 0 0 0 1 000 00 00 0008 44440004 0 1 44440004
6 H 00c60821 2000 0 0 0 0 0 0 0 0 0 0 0 0 001 04 01 0821 44440004 44440004 0 0

// File: compile.f
+incdir+verilog
verilog/id_pkg.sv
verilog/fwd_if.sv
verilog/issue_ctrl.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/operand_bypass.sv
verilog/branch_unit.sv
verilog/id_stage.sv
testbench/tb_id_stage.sv

// File: Makefile
TOP = tb_id_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: testbench/tb_id_stage.sv
`include "id_defines.svh"

module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int NCOL = 23;

    logic                      clk;
    logic                      reset;
    logic                      fs_valid;
    logic [`ID_XLEN-1:0]       fs_inst;
    logic [`ID_XLEN-1:0]       fs_pc;
    logic                      es_allowin;
    logic                      es_fw_valid, es_fw_we, ms_fw_valid, ms_fw_we, ws_fw_valid, ws_fw_we;
    logic [`ID_REG_ADDR_W-1:0] es_fw_addr, ms_fw_addr, ws_fw_addr;
    logic [`ID_XLEN-1:0]       es_fw_value, ms_fw_value, ws_fw_value;
    logic                      es_pending, ms_pending;
    logic                      ds_allowin, ds_to_es_valid;
    logic [`ID_XLEN-1:0]       ds_pc, rs_value, rt_value, br_target;
    logic [`ID_ALU_OP_W-1:0]   alu_op;
    logic                      src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8;
    logic                      gr_we, mem_we, load, br_taken;
    logic [`ID_REG_ADDR_W-1:0] dest;
    logic [`ID_IMM_W-1:0]      imm;

    // one row per stimulus line in file column order
    logic [31:0] vec [MAX_VEC][NCOL];
    byte         ops [MAX_VEC];
    logic [31:0] model [32];
    int          nvec, errors, cycles, cycle_limit, seed;
    int          passed, failed;

    id_stage i_id_stage (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run timed out after %0d cycles, the DUT never finished", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_fields(input int i, input logic [31:0] exp_rs,
                                input logic [31:0] exp_rt);
        logic [31:0] flags;
        flags = {25'd0, src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8, gr_we, mem_we, load};
        check("alu_op", 32'(alu_op), vec[i][15]);
        check("flags", flags, vec[i][16]);
        check("dest", 32'(dest), vec[i][17]);
        check("imm", 32'(imm), vec[i][18]);
        check("rs_value", rs_value, exp_rs);
        check("rt_value", rt_value, exp_rt);
        check("br_taken", 32'(br_taken), vec[i][21]);
        if (vec[i][21][0])
            check("br_target", br_target, vec[i][22]);
    endtask

    task automatic clear_inputs();
        fs_valid    = 1'b0;
        es_fw_valid = 1'b0;
        es_fw_we    = 1'b0;
        ms_fw_valid = 1'b0;
        ms_fw_we    = 1'b0;
        ws_fw_valid = 1'b0;
        ws_fw_we    = 1'b0;
        es_pending  = 1'b0;
        ms_pending  = 1'b0;
        es_allowin  = 1'b1;
    endtask

    // ws write of a file value or a random one
    task automatic write_reg(input int i, input bit rnd);
        logic [31:0] value;
        value = rnd ? $random(seed) : vec[i][11];
        ws_fw_valid = 1'b1;
        ws_fw_we    = 1'b1;
        ws_fw_addr  = vec[i][10][4:0];
        ws_fw_value = value;
        if (vec[i][10][4:0] != 0)
            model[vec[i][10][4:0]] = value;
        @(negedge clk);
        clear_inputs();
    endtask

    // execute, memory and writeback results of one vector
    task automatic drive_bypass(input int i);
        {es_fw_valid, es_fw_we, es_fw_addr, es_fw_value} =
            {{2{vec[i][3][0]}}, vec[i][4][4:0], vec[i][5]};
        {ms_fw_valid, ms_fw_we, ms_fw_addr, ms_fw_value} =
            {{2{vec[i][6][0]}}, vec[i][7][4:0], vec[i][8]};
        {ws_fw_valid, ws_fw_we, ws_fw_addr, ws_fw_value} =
            {{2{vec[i][9][0]}}, vec[i][10][4:0], vec[i][11]};
        es_pending = vec[i][12][0];
        ms_pending = vec[i][13][0];
        es_allowin = vec[i][14][0];
    endtask

    // source value while execute still waits on its load
    function automatic logic [31:0] value_past_execute(input int i, input logic [4:0] src);
        if (src == 0)
            return '0;
        if (vec[i][6][0] && vec[i][7][4:0] == src)
            return vec[i][8];
        if (vec[i][9][0] && vec[i][10][4:0] == src)
            return vec[i][11];
        return model[src];
    endfunction

    task automatic issue(input int i);
        logic [31:0] exp_rs;
        logic [31:0] exp_rt;
        logic [4:0]  rs_addr;
        logic [4:0]  rt_addr;
        rs_addr  = vec[i][1][25:21];
        rt_addr  = vec[i][1][20:16];
        fs_inst  = vec[i][1];
        fs_pc    = vec[i][2];
        fs_valid = 1'b1;
        exp_rs = (ops[i] == "C") ? model[rs_addr] : vec[i][19];
        exp_rt = (ops[i] == "C") ? model[rt_addr] : vec[i][20];
        #1 check("ds_allowin on an empty stage", 32'(ds_allowin), 1);
        @(posedge clk);
        @(negedge clk);
        fs_valid = 1'b0;
        // later results arrive after the accept edge
        drive_bypass(i);
        if (ops[i] == "S") begin
            repeat (3) begin
                #1 check("ds_to_es_valid in stall", 32'(ds_to_es_valid), 0);
                check("ds_allowin in stall", 32'(ds_allowin), 0);
                if (es_pending) begin
                    check("rs_value past pending execute", rs_value,
                          value_past_execute(i, rs_addr));
                    check("rt_value past pending execute", rt_value,
                          value_past_execute(i, rt_addr));
                end
                @(negedge clk);
            end
            es_pending = 1'b0;
            ms_pending = 1'b0;
        end else if (ops[i] == "H") begin
            // a new word waits at fetch while execute is blocked
            fs_valid = 1'b1;
            fs_inst  = ~vec[i][1];
            fs_pc    = vec[i][2] + 4;
            repeat (3) begin
                #1 check("ds_allowin in hold", 32'(ds_allowin), 0);
                check("ds_to_es_valid in hold", 32'(ds_to_es_valid), 1);
                check("ds_pc in hold", ds_pc, vec[i][2]);
                check_fields(i, exp_rs, exp_rt);
                @(negedge clk);
            end
            fs_valid   = 1'b0;
            es_allowin = 1'b1;
        end
        #1;
        while (!ds_to_es_valid) begin
            @(negedge clk);
            #1;
        end
        check("ds_pc", ds_pc, vec[i][2]);
        check_fields(i, exp_rs, exp_rt);
        // ws result lands in the register file at this edge
        @(negedge clk);
        if (ws_fw_valid && ws_fw_we && ws_fw_addr != 0)
            model[ws_fw_addr] = ws_fw_value;
        clear_inputs();
    endtask

    task automatic report_test(input int num, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d: ok", num);
            passed++;
        end else begin
            $display("test %0d: failed with %0d errors", num, errors - errs_before);
            failed++;
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    rc;
        string line;
        fd = $fopen("testbench/id_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/id_stim.txt");
            errors++;
            return;
        end
        while (nvec < MAX_VEC && !$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc == 0)
                break;
            if (line.len() < 4 || line[0] == "#")
                continue;
            rc = $sscanf(line,
                "%h %c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                vec[nvec][0], ops[nvec], vec[nvec][1], vec[nvec][2], vec[nvec][3],
                vec[nvec][4], vec[nvec][5], vec[nvec][6], vec[nvec][7], vec[nvec][8],
                vec[nvec][9], vec[nvec][10], vec[nvec][11], vec[nvec][12], vec[nvec][13],
                vec[nvec][14], vec[nvec][15], vec[nvec][16], vec[nvec][17], vec[nvec][18],
                vec[nvec][19], vec[nvec][20], vec[nvec][21], vec[nvec][22]);
            if (rc != 24) begin
                $display("stimulus line could not be parsed: %s", line);
                errors++;
            end else begin
                nvec++;
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int cur_test;
        int errs_before;
        clk = 1'b0;
        reset = 1'b1;
        fs_inst = '0;
        fs_pc = '0;
        {es_fw_addr, ms_fw_addr, ws_fw_addr} = '0;
        {es_fw_value, ms_fw_value, ws_fw_value} = '0;
        clear_inputs();
        seed = 63;
        foreach (model[r])
            model[r] = '0;
        load_vectors();
        cycle_limit = 40 * nvec + 8;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        cur_test = -1;
        errs_before = errors;
        for (int i = 0; i < nvec; i++) begin
            if (int'(vec[i][0]) != cur_test) begin
                if (cur_test >= 0)
                    report_test(cur_test, errs_before);
                cur_test = vec[i][0];
                errs_before = errors;
            end
            @(negedge clk);
            case (ops[i])
                "W": write_reg(i, 1'b0);
                "R": write_reg(i, 1'b1);
                default: issue(i);
            endcase
        end
        if (cur_test >= 0)
            report_test(cur_test, errs_before);
        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && nvec > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end
endmodule

// File: verilog/id_stage.sv
`include "id_defines.svh"

module id_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fs_valid,
    input  logic [`ID_XLEN-1:0]       fs_inst,
    input  logic [`ID_XLEN-1:0]       fs_pc,
    input  logic                      es_allowin,
    input  logic                      es_fw_valid,
    input  logic                      es_fw_we,
    input  logic [`ID_REG_ADDR_W-1:0] es_fw_addr,
    input  logic [`ID_XLEN-1:0]       es_fw_value,
    input  logic                      ms_fw_valid,
    input  logic                      ms_fw_we,
    input  logic [`ID_REG_ADDR_W-1:0] ms_fw_addr,
    input  logic [`ID_XLEN-1:0]       ms_fw_value,
    input  logic                      ws_fw_valid,
    input  logic                      ws_fw_we,
    input  logic [`ID_REG_ADDR_W-1:0] ws_fw_addr,
    input  logic [`ID_XLEN-1:0]       ws_fw_value,
    input  logic                      es_pending,
    input  logic                      ms_pending,
    output logic                      ds_allowin,
    output logic                      ds_to_es_valid,
    output logic [`ID_XLEN-1:0]       ds_pc,
    output logic [`ID_ALU_OP_W-1:0]   alu_op,
    output logic                      src1_is_sa,
    output logic                      src1_is_pc,
    output logic                      src2_is_imm,
    output logic                      src2_is_8,
    output logic                      gr_we,
    output logic                      mem_we,
    output logic                      load,
    output logic [`ID_REG_ADDR_W-1:0] dest,
    output logic [`ID_IMM_W-1:0]      imm,
    output logic [`ID_XLEN-1:0]       rs_value,
    output logic [`ID_XLEN-1:0]       rt_value,
    output logic                      br_taken,
    output logic [`ID_XLEN-1:0]       br_target
);
    logic                      ds_valid;
    logic                      hazard;
    logic [`ID_XLEN-1:0]       ds_inst;
    logic [`ID_XLEN-1:0]       rf_rdata1;
    logic [`ID_XLEN-1:0]       rf_rdata2;
    logic [`ID_REG_ADDR_W-1:0] rs;
    logic [`ID_REG_ADDR_W-1:0] rt;
    id_pkg::id_ctrl_t          ctrl;

    fwd_if es_fw ();
    fwd_if ms_fw ();
    fwd_if ws_fw ();

    assign es_fw.valid = es_fw_valid;
    assign es_fw.we    = es_fw_we;
    assign es_fw.addr  = es_fw_addr;
    assign es_fw.value = es_fw_value;
    assign ms_fw.valid = ms_fw_valid;
    assign ms_fw.we    = ms_fw_we;
    assign ms_fw.addr  = ms_fw_addr;
    assign ms_fw.value = ms_fw_value;
    assign ws_fw.valid = ws_fw_valid;
    assign ws_fw.we    = ws_fw_we;
    assign ws_fw.addr  = ws_fw_addr;
    assign ws_fw.value = ws_fw_value;

    assign rs = ds_inst[25:21];
    assign rt = ds_inst[20:16];

    // decoded fields to execute
    assign alu_op      = ctrl.alu_op;
    assign src1_is_sa  = ctrl.src1_is_sa;
    assign src1_is_pc  = ctrl.src1_is_pc;
    assign src2_is_imm = ctrl.src2_is_imm;
    assign src2_is_8   = ctrl.src2_is_8;
    assign gr_we       = ctrl.gr_we;
    assign mem_we      = ctrl.mem_we;
    assign load        = ctrl.load;
    assign dest        = ctrl.dest;
    assign imm         = ctrl.imm;

    issue_ctrl i_issue_ctrl (
        .clk(clk), .reset(reset),
        .fs_valid(fs_valid), .fs_inst(fs_inst), .fs_pc(fs_pc),
        .es_allowin(es_allowin), .hazard(hazard),
        .ds_allowin(ds_allowin), .ds_valid(ds_valid), .ds_to_es_valid(ds_to_es_valid),
        .ds_inst(ds_inst), .ds_pc(ds_pc)
    );

    inst_decoder i_inst_decoder (.inst(ds_inst), .ctrl(ctrl));

    regfile i_regfile (
        .clk(clk), .raddr1(rs), .raddr2(rt), .wr(ws_fw),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    operand_bypass i_operand_bypass (
        .ds_valid(ds_valid), .raddr1(rs), .raddr2(rt),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .es_pending(es_pending), .ms_pending(ms_pending),
        .es_fw(es_fw), .ms_fw(ms_fw), .ws_fw(ws_fw),
        .rs_value(rs_value), .rt_value(rt_value), .hazard(hazard)
    );

    branch_unit i_branch_unit (
        .ds_valid(ds_valid), .br_kind(ctrl.br_kind), .ds_pc(ds_pc),
        .imm(ctrl.imm), .jidx(ds_inst[`ID_JIDX_W-1:0]),
        .rs_value(rs_value), .rt_value(rt_value),
        .br_taken(br_taken), .br_target(br_target)
    );
endmodule

// File: verilog/branch_unit.sv
`include "id_defines.svh"

module branch_unit (
    input  logic                  ds_valid,
    input  id_pkg::br_kind_t      br_kind,
    input  logic [`ID_XLEN-1:0]   ds_pc,
    input  logic [`ID_IMM_W-1:0]  imm,
    input  logic [`ID_JIDX_W-1:0] jidx,
    input  logic [`ID_XLEN-1:0]   rs_value,
    input  logic [`ID_XLEN-1:0]   rt_value,
    output logic                  br_taken,
    output logic [`ID_XLEN-1:0]   br_target
);
    logic [`ID_XLEN-1:0] seq_pc;
    logic [`ID_XLEN-1:0] br_offset;
    logic                rs_eq_rt;
    logic                rs_neg;
    logic                rs_gtz;
    logic                cond;

    assign seq_pc    = ds_pc + `ID_XLEN'(4);
    // word offset, sign extended
    assign br_offset = {{(`ID_XLEN-`ID_IMM_W-2){imm[`ID_IMM_W-1]}}, imm, 2'b00};
    assign rs_eq_rt  = (rs_value == rt_value);
    assign rs_neg    = rs_value[`ID_XLEN-1];
    assign rs_gtz    = !rs_neg && (rs_value != '0);

    always_comb begin
        case (br_kind)
            id_pkg::BR_BEQ:  cond = rs_eq_rt;
            id_pkg::BR_BNE:  cond = !rs_eq_rt;
            id_pkg::BR_BGEZ: cond = !rs_neg;
            id_pkg::BR_BGTZ: cond = rs_gtz;
            id_pkg::BR_BLEZ: cond = !rs_gtz;
            id_pkg::BR_BLTZ: cond = rs_neg;
            id_pkg::BR_J, id_pkg::BR_JAL, id_pkg::BR_JR: cond = 1'b1;
            default:         cond = 1'b0;
        endcase

        case (br_kind)
            id_pkg::BR_JR:               br_target = rs_value;
            id_pkg::BR_J, id_pkg::BR_JAL: br_target = {seq_pc[`ID_XLEN-1:28], jidx, 2'b00};
            default:                     br_target = seq_pc + br_offset;
        endcase
    end

    assign br_taken = ds_valid && cond;
endmodule

// File: verilog/operand_bypass.sv
`include "id_defines.svh"

module operand_bypass (
    input  logic                      ds_valid,
    input  logic [`ID_REG_ADDR_W-1:0] raddr1,
    input  logic [`ID_REG_ADDR_W-1:0] raddr2,
    input  logic [`ID_XLEN-1:0]       rdata1,
    input  logic [`ID_XLEN-1:0]       rdata2,
    input  logic                      es_pending,
    input  logic                      ms_pending,
    fwd_if.sink                       es_fw,
    fwd_if.sink                       ms_fw,
    fwd_if.sink                       ws_fw,
    output logic [`ID_XLEN-1:0]       rs_value,
    output logic [`ID_XLEN-1:0]       rt_value,
    output logic                      hazard
);
    logic es_wait;
    logic ms_wait;

    // stage result targets this nonzero source
    function automatic logic hit(input logic valid, input logic we,
                                 input logic [`ID_REG_ADDR_W-1:0] addr,
                                 input logic [`ID_REG_ADDR_W-1:0] src);
        return valid && we && (addr == src) && (src != '0);
    endfunction

    // newest stage first, execute skipped while its load is outstanding
    function automatic logic [`ID_XLEN-1:0] forward(input logic [`ID_REG_ADDR_W-1:0] src,
                                                    input logic [`ID_XLEN-1:0] rf_value);
        if (src == '0)
            return '0;
        if (!es_pending && hit(es_fw.valid, es_fw.we, es_fw.addr, src))
            return es_fw.value;
        if (hit(ms_fw.valid, ms_fw.we, ms_fw.addr, src))
            return ms_fw.value;
        if (hit(ws_fw.valid, ws_fw.we, ws_fw.addr, src))
            return ws_fw.value;
        return rf_value;
    endfunction

    always_comb begin
        rs_value = forward(raddr1, rdata1);
        rt_value = forward(raddr2, rdata2);
    end

    // load-use, either source waiting on execute or memory
    assign es_wait = es_pending && (hit(es_fw.valid, es_fw.we, es_fw.addr, raddr1)
                                 || hit(es_fw.valid, es_fw.we, es_fw.addr, raddr2));
    assign ms_wait = ms_pending && (hit(ms_fw.valid, ms_fw.we, ms_fw.addr, raddr1)
                                 || hit(ms_fw.valid, ms_fw.we, ms_fw.addr, raddr2));
    assign hazard  = ds_valid && (es_wait || ms_wait);
endmodule

// File: verilog/regfile.sv
`include "id_defines.svh"

module regfile (
    input  logic                      clk,
    input  logic [`ID_REG_ADDR_W-1:0] raddr1,
    input  logic [`ID_REG_ADDR_W-1:0] raddr2,
    fwd_if.sink                       wr,
    output logic [`ID_XLEN-1:0]       rdata1,
    output logic [`ID_XLEN-1:0]       rdata2
);
    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    // writeback result lands at the edge, r0 stays untouched
    always_ff @(posedge clk) begin
        if (wr.valid && wr.we && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.value;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

// File: verilog/inst_decoder.sv
`include "id_defines.svh"

module inst_decoder (
    input  logic [`ID_XLEN-1:0] inst,
    output id_pkg::id_ctrl_t    ctrl
);
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sa;
    logic [5:0] func;
    logic       special;
    logic       r_alu;
    logic       inst_addu, inst_subu, inst_slt, inst_sltu;
    logic       inst_and, inst_or, inst_xor, inst_nor;
    logic       inst_sll, inst_srl, inst_sra, inst_jr;
    logic       inst_addiu, inst_lui, inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz;
    logic       inst_blez, inst_bltz, inst_j, inst_jal;
    logic       dst_is_rt;

    assign op   = inst[31:26];
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];
    assign sa   = inst[10:6];
    assign func = inst[5:0];

    assign special = (op == `ID_OP_SPECIAL);
    // three-register forms need sa zero
    assign r_alu   = special && (sa == 5'd0);

    assign inst_addu  = r_alu && (func == `ID_FN_ADDU);
    assign inst_subu  = r_alu && (func == `ID_FN_SUBU);
    assign inst_slt   = r_alu && (func == `ID_FN_SLT);
    assign inst_sltu  = r_alu && (func == `ID_FN_SLTU);
    assign inst_and   = r_alu && (func == `ID_FN_AND);
    assign inst_or    = r_alu && (func == `ID_FN_OR);
    assign inst_xor   = r_alu && (func == `ID_FN_XOR);
    assign inst_nor   = r_alu && (func == `ID_FN_NOR);
    // shifts by sa need rs zero
    assign inst_sll   = special && (rs == 5'd0) && (func == `ID_FN_SLL);
    assign inst_srl   = special && (rs == 5'd0) && (func == `ID_FN_SRL);
    assign inst_sra   = special && (rs == 5'd0) && (func == `ID_FN_SRA);
    assign inst_jr    = r_alu && (func == `ID_FN_JR) && (rt == 5'd0) && (rd == 5'd0);
    assign inst_addiu = (op == `ID_OP_ADDIU);
    assign inst_lui   = (op == `ID_OP_LUI) && (rs == 5'd0);
    assign inst_lw    = (op == `ID_OP_LW);
    assign inst_sw    = (op == `ID_OP_SW);
    assign inst_beq   = (op == `ID_OP_BEQ);
    assign inst_bne   = (op == `ID_OP_BNE);
    assign inst_bgez  = (op == `ID_OP_REGIMM) && (rt == `ID_RT_BGEZ);
    assign inst_bltz  = (op == `ID_OP_REGIMM) && (rt == `ID_RT_BLTZ);
    assign inst_bgtz  = (op == `ID_OP_BGTZ) && (rt == 5'd0);
    assign inst_blez  = (op == `ID_OP_BLEZ) && (rt == 5'd0);
    assign inst_j     = (op == `ID_OP_J);
    assign inst_jal   = (op == `ID_OP_JAL);

    assign dst_is_rt = inst_addiu || inst_lui || inst_lw;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[id_pkg::ALU_ADD]  = inst_addu || inst_addiu || inst_lw || inst_sw || inst_jal;
        ctrl.alu_op[id_pkg::ALU_SUB]  = inst_subu;
        ctrl.alu_op[id_pkg::ALU_SLT]  = inst_slt;
        ctrl.alu_op[id_pkg::ALU_SLTU] = inst_sltu;
        ctrl.alu_op[id_pkg::ALU_AND]  = inst_and;
        ctrl.alu_op[id_pkg::ALU_NOR]  = inst_nor;
        ctrl.alu_op[id_pkg::ALU_OR]   = inst_or;
        ctrl.alu_op[id_pkg::ALU_XOR]  = inst_xor;
        ctrl.alu_op[id_pkg::ALU_SLL]  = inst_sll;
        ctrl.alu_op[id_pkg::ALU_SRL]  = inst_srl;
        ctrl.alu_op[id_pkg::ALU_SRA]  = inst_sra;
        ctrl.alu_op[id_pkg::ALU_LUI]  = inst_lui;

        if (inst_beq)       ctrl.br_kind = id_pkg::BR_BEQ;
        else if (inst_bne)  ctrl.br_kind = id_pkg::BR_BNE;
        else if (inst_bgez) ctrl.br_kind = id_pkg::BR_BGEZ;
        else if (inst_bgtz) ctrl.br_kind = id_pkg::BR_BGTZ;
        else if (inst_blez) ctrl.br_kind = id_pkg::BR_BLEZ;
        else if (inst_bltz) ctrl.br_kind = id_pkg::BR_BLTZ;
        else if (inst_j)    ctrl.br_kind = id_pkg::BR_J;
        else if (inst_jal)  ctrl.br_kind = id_pkg::BR_JAL;
        else if (inst_jr)   ctrl.br_kind = id_pkg::BR_JR;
        else                ctrl.br_kind = id_pkg::BR_NONE;

        ctrl.src1_is_sa  = inst_sll || inst_srl || inst_sra;
        ctrl.src1_is_pc  = inst_jal;
        ctrl.src2_is_imm = inst_addiu || inst_lui || inst_lw || inst_sw;
        ctrl.src2_is_8   = inst_jal;
        // unknown encodings and the all-zero nop write nothing
        ctrl.gr_we  = (inst_addu || inst_subu || inst_slt || inst_sltu || inst_and || inst_or
                    || inst_xor || inst_nor || inst_sll || inst_srl || inst_sra
                    || inst_addiu || inst_lui || inst_lw || inst_jal) && (inst != '0);
        ctrl.mem_we = inst_sw;
        ctrl.load   = inst_lw;
        ctrl.dest   = inst_jal ? `ID_LINK_REG : (dst_is_rt ? rt : rd);
        ctrl.imm    = inst[`ID_IMM_W-1:0];
    end

    always_comb begin
        alu_onehot: assert ($onehot0(ctrl.alu_op));
    end
endmodule

// File: verilog/issue_ctrl.sv
`include "id_defines.svh"

module issue_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                fs_valid,
    input  logic [`ID_XLEN-1:0] fs_inst,
    input  logic [`ID_XLEN-1:0] fs_pc,
    input  logic                es_allowin,
    input  logic                hazard,
    output logic                ds_allowin,
    output logic                ds_valid,
    output logic                ds_to_es_valid,
    output logic [`ID_XLEN-1:0] ds_inst,
    output logic [`ID_XLEN-1:0] ds_pc
);
    logic ds_ready_go;

    // only a load-use hazard holds the stage
    assign ds_ready_go    = !hazard;
    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_valid;
        end
    end

    // payload, loaded on accept
    always_ff @(posedge clk) begin
        if (fs_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    // a held instruction must not change under execute
    held_stable: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !(ds_to_es_valid && es_allowin) |=> $stable(ds_inst) && $stable(ds_pc));
endmodule

// File: verilog/fwd_if.sv
`include "id_defines.svh"

// one later stage's result, as seen by decode
interface fwd_if;
    logic                      valid;
    logic                      we;
    logic [`ID_REG_ADDR_W-1:0] addr;
    logic [`ID_XLEN-1:0]       value;

    // producing stage
    modport source (output valid, we, addr, value);

    // decode side, bypass and register file write
    modport sink (input valid, we, addr, value);
endinterface

// File: verilog/id_pkg.sv
`include "id_defines.svh"

package id_pkg;

    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    // bit positions inside alu_op_t, one-hot
    typedef enum int unsigned {
        ALU_ADD  = 0,
        ALU_SUB  = 1,
        ALU_SLT  = 2,
        ALU_SLTU = 3,
        ALU_AND  = 4,
        ALU_NOR  = 5,
        ALU_OR   = 6,
        ALU_XOR  = 7,
        ALU_SLL  = 8,
        ALU_SRL  = 9,
        ALU_SRA  = 10,
        ALU_LUI  = 11
    } alu_bit_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGEZ,
        BR_BGTZ,
        BR_BLEZ,
        BR_BLTZ,
        BR_J,
        BR_JAL,
        BR_JR
    } br_kind_t;

    typedef struct packed {
        alu_op_t                   alu_op;
        br_kind_t                  br_kind;
        logic                      src1_is_sa;
        logic                      src1_is_pc;
        logic                      src2_is_imm;
        logic                      src2_is_8;
        logic                      gr_we;
        logic                      mem_we;
        logic                      load;
        logic [`ID_REG_ADDR_W-1:0] dest;
        logic [`ID_IMM_W-1:0]      imm;
    } id_ctrl_t;

endpackage

// File: verilog/id_defines.svh
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// datapath widths
`define ID_XLEN        32
`define ID_REG_ADDR_W  5
`define ID_NUM_REGS    32
`define ID_ALU_OP_W    12
`define ID_IMM_W       16
`define ID_JIDX_W      26

// jal writes the return address here
`define ID_LINK_REG    5'd31

// primary opcodes
`define ID_OP_SPECIAL  6'h00
`define ID_OP_REGIMM   6'h01
`define ID_OP_J        6'h02
`define ID_OP_JAL      6'h03
`define ID_OP_BEQ      6'h04
`define ID_OP_BNE      6'h05
`define ID_OP_BLEZ     6'h06
`define ID_OP_BGTZ     6'h07
`define ID_OP_ADDIU    6'h09
`define ID_OP_LUI      6'h0f
`define ID_OP_LW       6'h23
`define ID_OP_SW       6'h2b

// function codes under SPECIAL
`define ID_FN_SLL      6'h00
`define ID_FN_SRL      6'h02
`define ID_FN_SRA      6'h03
`define ID_FN_JR       6'h08
`define ID_FN_ADDU     6'h21
`define ID_FN_SUBU     6'h23
`define ID_FN_AND      6'h24
`define ID_FN_OR       6'h25
`define ID_FN_XOR      6'h26
`define ID_FN_NOR      6'h27
`define ID_FN_SLT      6'h2a
`define ID_FN_SLTU     6'h2b

// rt field under REGIMM
`define ID_RT_BLTZ     5'h00
`define ID_RT_BGEZ     5'h01

`endif
